/* hw/isa_pkg.sv */
// Instruction set definitions shared by every pipeline stage.
// Holds the data widths, the instruction field layout and the opcode encoding.

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;

    localparam int NUM_REGS = 64;

    // all-zero word decodes as NOP
    localparam word_t NOP_INSTR = 32'h0000_0000;

    // field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam int RD_HI  = 25;
    localparam int RD_LO  = 20;
    localparam int RS0_HI = 19;
    localparam int RS0_LO = 14;
    localparam int RS1_HI = 13;
    localparam int RS1_LO = 8;

    // immediate widths: I-type and store/branch
    localparam int IMM_I_W = 14;
    localparam int IMM_S_W = 8;

    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLT  = 6'd6,
        OP_ADDI = 6'd7,
        OP_LW   = 6'd8,
        OP_SW   = 6'd9,
        OP_BEQ  = 6'd10,
        OP_BNE  = 6'd11,
        OP_OUT  = 6'd12
    } opcode_e;

endpackage

/* hw/pipe_pkg.sv */
// Pipeline register layouts passed between the five stages.
// Each stage drives one struct into the next; the forwarding select lives here too.

package pipe_pkg;

    // fetch/decode
    typedef struct packed {
        logic          valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } fd_t;

    // decoded control bits, travel with the instruction
    typedef struct packed {
        isa_pkg::opcode_e   op;
        isa_pkg::reg_addr_t rd;
        logic               reg_we;
        logic               mem_rd;
        logic               mem_we;
        logic               branch;
        logic               out;
    } ctrl_t;

    // decode/execute
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        ctrl_t              ctrl;
        isa_pkg::reg_addr_t rs0;
        isa_pkg::reg_addr_t rs1;
        isa_pkg::word_t     op0;
        isa_pkg::word_t     op1;
        isa_pkg::word_t     imm;
    } de_t;

    // execute/memory
    typedef struct packed {
        logic           valid;
        ctrl_t          ctrl;
        isa_pkg::word_t alu;
        isa_pkg::word_t store_data;
    } em_t;

    // memory/write-back, drives the register file write port
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t rd;
        logic               reg_we;
        isa_pkg::word_t     wdata;
    } mw_t;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_EM = 2'd1,
        FWD_MW = 2'd2
    } fwd_sel_e;

endpackage

/* hw/pipeline_ctrl.sv */
// Hazard and stage-enable control for the pipeline.
// Picks forwarding sources, inserts load-use bubbles and flushes on taken branches.
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  logic               hold,
    input  isa_pkg::reg_addr_t dec_rs0,
    input  isa_pkg::reg_addr_t dec_rs1,
    input  pipe_pkg::de_t      de,
    input  pipe_pkg::em_t      em,
    input  pipe_pkg::mw_t      mw,
    input  logic               branch_taken,
    input  logic               mem_busy,
    output pipe_pkg::fwd_sel_e fwd0,
    output pipe_pkg::fwd_sel_e fwd1,
    output logic               advance_front,
    output logic               advance_back,
    output logic               bubble_de,
    output logic               flush_fd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic run;
    logic de_writes, em_writes;
    logic load_use;

    ////////////////////////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////////////////////////

    assign de_writes = de.valid && de.ctrl.reg_we && (de.ctrl.rd != '0);
    assign em_writes = em.valid && em.ctrl.reg_we && (em.ctrl.rd != '0);

    // selects take effect once the decoded instruction sits in execute:
    // whatever is in execute now will then be in execute/memory,
    // and whatever is in execute/memory will be in memory/write-back
    always_comb begin
        fwd0 = FWD_RF;
        if (de_writes && de.ctrl.rd == dec_rs0) begin
            fwd0 = FWD_EM;
        end else if (em_writes && em.ctrl.rd == dec_rs0) begin
            fwd0 = FWD_MW;
        end
    end

    always_comb begin
        fwd1 = FWD_RF;
        if (de_writes && de.ctrl.rd == dec_rs1) begin
            fwd1 = FWD_EM;
        end else if (em_writes && em.ctrl.rd == dec_rs1) begin
            fwd1 = FWD_MW;
        end
    end

    ////////////////////////////////////////////////////////////
    // stall and flush
    ////////////////////////////////////////////////////////////

    // load data only exists in memory/write-back, one bubble covers the gap
    assign load_use = de_writes && de.ctrl.mem_rd &&
                      (de.ctrl.rd == dec_rs0 || de.ctrl.rd == dec_rs1);

    assign run           = !hold && !mem_busy;
    assign advance_back  = run;
    assign advance_front = run && !load_use;
    assign flush_fd      = run && branch_taken;
    assign bubble_de     = run && (load_use || branch_taken);

    a_no_flush_in_hold: assert property (@(posedge clk) disable iff (!rstn)
        hold |-> !flush_fd);

    // pending write-back stays put while the back end is frozen
    a_wb_frozen: assert property (@(posedge clk) disable iff (!rstn)
        (mw.valid && mw.reg_we && !run) |=> $stable(mw));

endmodule

/* hw/fetch_stage.sv */
// Fetch stage with program counter and instruction memory.
// The load port writes instruction words while the core is held.
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          advance,
    input  logic                          flush,
    input  logic                          redirect,
    input  isa_pkg::word_t                redirect_pc,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  isa_pkg::word_t                prog_data,
    output pipe_pkg::fd_t                 fd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int IW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t pc, pc_next;
    word_t instr_q;

    // instr_q always holds imem[pc] after the edge
    always_comb begin
        if (!rstn) begin
            pc_next = '0;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = pc + 32'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        instr_q <= imem[pc_next[IW+1:2]];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= '0;
            fd <= '0;
        end else begin
            pc <= pc_next;
            if (flush) begin
                fd <= '0;
            end else if (advance) begin
                fd <= '{valid: 1'b1, pc: pc, instr: instr_q};
            end
        end
    end

endmodule

/* hw/decode_stage.sv */
// Decode stage: splits the instruction word, reads the register file
// and loads decode/execute. Forwarded operands are chosen as the entry enters execute.
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               advance,
    input  logic               bubble,
    input  pipe_pkg::fd_t      fd,
    input  pipe_pkg::fwd_sel_e fwd0,
    input  pipe_pkg::fwd_sel_e fwd1,
    output isa_pkg::reg_addr_t rf_raddr0,
    output isa_pkg::reg_addr_t rf_raddr1,
    input  isa_pkg::word_t     rf_rdata0,
    input  isa_pkg::word_t     rf_rdata1,
    input  pipe_pkg::em_t      em,
    input  pipe_pkg::mw_t      mw,
    output isa_pkg::reg_addr_t dec_rs0,
    output isa_pkg::reg_addr_t dec_rs1,
    output pipe_pkg::de_t      de
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0] op_raw;
    opcode_e    op;
    de_t        de_n, de_q;
    fwd_sel_e   fwd0_q, fwd1_q;

    assign op_raw    = fd.instr[OPC_HI:OPC_LO];
    assign dec_rs0   = fd.instr[RS0_HI:RS0_LO];
    assign dec_rs1   = fd.instr[RS1_HI:RS1_LO];
    assign rf_raddr0 = dec_rs0;
    assign rf_raddr1 = dec_rs1;

    // unknown opcodes fall back to NOP
    assign op = (fd.valid && op_raw <= 6'(OP_OUT)) ? opcode_e'(op_raw) : OP_NOP;

    always_comb begin
        de_n             = '0;
        de_n.valid       = fd.valid;
        de_n.pc          = fd.pc;
        de_n.ctrl.op     = op;
        de_n.ctrl.rd     = fd.instr[RD_HI:RD_LO];
        de_n.ctrl.reg_we = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                      OP_SLT, OP_ADDI, OP_LW};
        de_n.ctrl.mem_rd = (op == OP_LW);
        de_n.ctrl.mem_we = (op == OP_SW);
        de_n.ctrl.branch = (op == OP_BEQ) || (op == OP_BNE);
        de_n.ctrl.out    = (op == OP_OUT);
        de_n.rs0         = dec_rs0;
        de_n.rs1         = dec_rs1;
        de_n.op0         = rf_rdata0;
        de_n.op1         = rf_rdata1;
        if (op == OP_ADDI || op == OP_LW) begin
            de_n.imm = {{(32-IMM_I_W){fd.instr[IMM_I_W-1]}}, fd.instr[IMM_I_W-1:0]};
        end else begin
            de_n.imm = {{(32-IMM_S_W){fd.instr[IMM_S_W-1]}}, fd.instr[IMM_S_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || bubble) begin
            de_q   <= '0;
            fwd0_q <= FWD_RF;
            fwd1_q <= FWD_RF;
        end else if (advance) begin
            de_q   <= de_n;
            fwd0_q <= fwd0;
            fwd1_q <= fwd1;
        end
    end

    // operand muxes on the registered entry
    always_comb begin
        de = de_q;
        case (fwd0_q)
            FWD_EM:  de.op0 = em.alu;
            FWD_MW:  de.op0 = mw.wdata;
            default: de.op0 = de_q.op0;
        endcase
        case (fwd1_q)
            FWD_EM:  de.op1 = em.alu;
            FWD_MW:  de.op1 = mw.wdata;
            default: de.op1 = de_q.op1;
        endcase
    end

endmodule

/* hw/register_file.sv */
// 64-entry register file, two read ports and one write port.
// Reads see a write in the same cycle; register 0 reads as zero.
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               rstn,
    input  isa_pkg::reg_addr_t raddr0,
    input  isa_pkg::reg_addr_t raddr1,
    output isa_pkg::word_t     rdata0,
    output isa_pkg::word_t     rdata1,
    input  pipe_pkg::mw_t      mw
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [NUM_REGS];
    logic  we;

    assign we = mw.valid && mw.reg_we && (mw.rd != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[mw.rd] <= mw.wdata;
        end
    end

    // write-first bypass
    assign rdata0 = (raddr0 == '0) ? '0 : (we && mw.rd == raddr0) ? mw.wdata : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : (we && mw.rd == raddr1) ? mw.wdata : regs[raddr1];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rstn)
        (mw.valid && mw.reg_we && mw.rd == '0) |=> regs[0] == '0);

endmodule

/* hw/exec_stage.sv */
// Execute stage: ALU, address generation and branch resolution.
// A taken branch reports its target; the branch itself leaves as a bubble.
`timescale 1ns/1ps

module exec_stage (
    input  logic           clk,
    input  logic           rstn,
    input  logic           advance,
    input  logic           bubble,
    input  pipe_pkg::de_t  de,
    output logic           branch_taken,
    output isa_pkg::word_t redirect_pc,
    output pipe_pkg::em_t  em
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t a, b, alu;
    logic  equal;

    assign a     = de.op0;
    assign b     = de.op1;
    assign equal = (a == b);

    always_comb begin
        case (de.ctrl.op)
            OP_ADD:  alu = a + b;
            OP_SUB:  alu = a - b;
            OP_AND:  alu = a & b;
            OP_OR:   alu = a | b;
            OP_XOR:  alu = a ^ b;
            OP_SLT:  alu = {31'b0, $signed(a) < $signed(b)};
            // address or immediate add
            OP_ADDI, OP_LW, OP_SW: alu = a + de.imm;
            OP_OUT:  alu = a;
            default: alu = '0;
        endcase
    end

    assign branch_taken = de.valid && de.ctrl.branch &&
                          ((de.ctrl.op == OP_BEQ) ? equal : !equal);
    assign redirect_pc  = de.pc + 32'd4 + {de.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            em <= '0;
        end else if (advance) begin
            em.valid      <= de.valid && !bubble;
            em.ctrl       <= de.ctrl;
            em.alu        <= alu;
            em.store_data <= b;
        end
    end

endmodule

/* hw/mem_stage.sv */
// Memory stage with word-addressed data memory and the byte output port.
// A pending output byte waits for tx_full low and stalls the pipeline meanwhile.
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rstn,
    input  logic           advance,
    input  pipe_pkg::em_t  em,
    output logic           mem_busy,
    input  logic           tx_full,
    output isa_pkg::byte_t tx_data,
    output logic           tx_wr_en,
    output pipe_pkg::mw_t  mw
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int DW = $clog2(DMEM_WORDS);

    word_t          dmem [DMEM_WORDS];
    logic [DW-1:0]  idx;
    logic           tx_pend;
    byte_t          tx_q;
    logic           out_in;

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    assign idx    = em.alu[DW-1:0];
    assign out_in = advance && em.valid && em.ctrl.out;

    assign mem_busy = tx_pend && tx_full;
    // no strobe while hold freezes the pipeline
    assign tx_wr_en = tx_pend && !tx_full && advance;
    assign tx_data  = tx_q;

    always_ff @(posedge clk) begin
        if (advance && em.valid && em.ctrl.mem_we) begin
            dmem[idx] <= em.store_data;
        end
        if (out_in) begin
            tx_q <= em.alu[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_pend <= 1'b0;
            mw      <= '0;
        end else begin
            // a new byte may replace the one leaving this cycle
            if (out_in) begin
                tx_pend <= 1'b1;
            end else if (tx_wr_en) begin
                tx_pend <= 1'b0;
            end
            if (advance) begin
                mw.valid  <= em.valid;
                mw.rd     <= em.ctrl.rd;
                mw.reg_we <= em.ctrl.reg_we;
                mw.wdata  <= em.ctrl.mem_rd ? dmem[idx] : em.alu;
            end
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
        !(tx_wr_en && tx_full));

endmodule

/* hw/cpu_top.sv */
// Top level of the five-stage pipeline core.
// Connects the stages, register file and control; programs are loaded while hold is high.
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          hold,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  isa_pkg::word_t                prog_data,
    output isa_pkg::byte_t                tx_data,
    output logic                          tx_wr_en,
    input  logic                          tx_full
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fd_t       fd;
    de_t       de;
    em_t       em;
    mw_t       mw;
    fwd_sel_e  fwd0, fwd1;
    reg_addr_t dec_rs0, dec_rs1;
    reg_addr_t rf_raddr0, rf_raddr1;
    word_t     rf_rdata0, rf_rdata1;
    word_t     redirect_pc;
    logic      branch_taken, mem_busy;
    logic      advance_front, advance_back, bubble_de, flush_fd;

    pipeline_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .hold(hold),
        .dec_rs0(dec_rs0), .dec_rs1(dec_rs1),
        .de(de), .em(em), .mw(mw),
        .branch_taken(branch_taken), .mem_busy(mem_busy),
        .fwd0(fwd0), .fwd1(fwd1),
        .advance_front(advance_front), .advance_back(advance_back),
        .bubble_de(bubble_de), .flush_fd(flush_fd)
    );

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk(clk), .rstn(rstn),
        .advance(advance_front), .flush(flush_fd),
        .redirect(flush_fd), .redirect_pc(redirect_pc),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .fd(fd)
    );

    decode_stage u_decode (
        .clk(clk), .rstn(rstn),
        .advance(advance_front), .bubble(bubble_de),
        .fd(fd), .fwd0(fwd0), .fwd1(fwd1),
        .rf_raddr0(rf_raddr0), .rf_raddr1(rf_raddr1),
        .rf_rdata0(rf_rdata0), .rf_rdata1(rf_rdata1),
        .em(em), .mw(mw),
        .dec_rs0(dec_rs0), .dec_rs1(dec_rs1),
        .de(de)
    );

    register_file u_rf (
        .clk(clk), .rstn(rstn),
        .raddr0(rf_raddr0), .raddr1(rf_raddr1),
        .rdata0(rf_rdata0), .rdata1(rf_rdata1),
        .mw(mw)
    );

    exec_stage u_exec (
        .clk(clk), .rstn(rstn),
        .advance(advance_back), .bubble(flush_fd),
        .de(de),
        .branch_taken(branch_taken), .redirect_pc(redirect_pc),
        .em(em)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk(clk), .rstn(rstn),
        .advance(advance_back), .em(em), .mem_busy(mem_busy),
        .tx_full(tx_full), .tx_data(tx_data), .tx_wr_en(tx_wr_en),
        .mw(mw)
    );

endmodule

/* sim/tb_cpu.sv */
// Testbench for the five-stage pipeline core.
// Loads random programs, runs them and checks the output bytes against an ISA model.
`timescale 1ns/1ps

module tb_cpu;
    import isa_pkg::*;

    localparam int IMEM_WORDS     = 256;
    localparam int DMEM_WORDS     = 256;
    localparam int IW             = $clog2(IMEM_WORDS);
    localparam int DW             = $clog2(DMEM_WORDS);
    localparam int NUM_PROGS      = 20;
    localparam int MAX_INSTR      = 60;
    localparam int TIMEOUT_CYCLES = NUM_PROGS * (MAX_INSTR * 8 + 200);
    // BEQ r0,r0,-1 spins in place
    localparam word_t HALT_INSTR  = {OP_BEQ, 6'd0, 6'd0, 6'd0, 8'hff};

    logic          clk = 1'b0;
    logic          rstn;
    logic          hold;
    logic          prog_we;
    logic [IW-1:0] prog_addr;
    word_t         prog_data;
    byte_t         tx_data;
    logic          tx_wr_en;
    logic          tx_full;

    // program image and ISA model state
    word_t         prog [MAX_INSTR];
    int            prog_len;
    word_t         model_regs [NUM_REGS];
    word_t         model_mem [DMEM_WORDS];
    byte_t         exp_q [$];

    int            cycles = 0;
    int            prog_num = 0;
    int            got_count = 0;
    int            bytes_checked = 0;
    int            value_errs = 0;
    int            proto_errs = 0;

    cpu_top #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) i_dut (
        .clk(clk),
        .rstn(rstn),
        .hold(hold),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .tx_data(tx_data),
        .tx_wr_en(tx_wr_en),
        .tx_full(tx_full)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // instruction encoding and random program
    ////////////////////////////////////////////////////////////

    function automatic word_t enc_r(opcode_e op, reg_addr_t rd, reg_addr_t rs0, reg_addr_t rs1);
        return {op, rd, rs0, rs1, 8'h00};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rd, reg_addr_t rs0,
                                    logic [13:0] imm);
        return {op, rd, rs0, imm};
    endfunction

    function automatic word_t enc_s(opcode_e op, reg_addr_t rs0, reg_addr_t rs1,
                                    logic [7:0] imm);
        return {op, 6'd0, rs0, rs1, imm};
    endfunction

    // mostly a small pool so results get reused soon
    function automatic reg_addr_t pick_reg();
        if ($urandom % 5 != 0) begin
            return reg_addr_t'($urandom % 8);
        end
        return reg_addr_t'($urandom % NUM_REGS);
    endfunction

    task automatic make_program();
        int         nb;
        int         i;
        int         kind;
        reg_addr_t  rd, s0, s1, base;
        logic [7:0] imm8;
        nb = 8 + int'($urandom % 49);
        i  = 0;
        while (i < nb) begin
            kind = int'($urandom % 16);
            rd   = pick_reg();
            s0   = pick_reg();
            s1   = pick_reg();
            base = ($urandom % 4 == 0) ? s0 : 6'd0;
            imm8 = 8'($urandom % 8);
            if (kind == 15 && i + 3 <= nb) begin
                // store, load back, print the loaded value at once
                prog[i]   = enc_s(OP_SW, 6'd0, s1, imm8);
                prog[i+1] = enc_i(OP_LW, rd, 6'd0, 14'(imm8));
                prog[i+2] = enc_r(OP_OUT, 6'd0, rd, 6'd0);
                i = i + 3;
            end else begin
                case (kind)
                    0, 1, 2:       prog[i] = enc_i(OP_ADDI, rd, s0, 14'($urandom));
                    8:             prog[i] = enc_i(OP_LW, rd, base, 14'(imm8));
                    9:             prog[i] = enc_s(OP_SW, base, s1, imm8);
                    11, 12, 13:    prog[i] = enc_r(OP_OUT, 6'd0, s0, 6'd0);
                    10: begin
                        // forward only and never past the final OUT
                        imm8    = 8'($urandom % (nb - i));
                        prog[i] = enc_s(($urandom % 2 == 0) ? OP_BEQ : OP_BNE, s0, s1, imm8);
                    end
                    14: begin
                        if ($urandom % 2 == 0) begin
                            prog[i] = NOP_INSTR;
                        end else begin
                            prog[i] = {6'(13 + $urandom % 51), 26'($urandom)};
                        end
                    end
                    default: begin
                        prog[i] = enc_r(opcode_e'(6'(1 + $urandom % 6)), rd, s0, s1);
                    end
                endcase
                i = i + 1;
            end
        end
        prog[nb]   = enc_r(OP_OUT, 6'd0, pick_reg(), 6'd0);
        prog[nb+1] = HALT_INSTR;
        prog_len   = nb + 2;
    endtask

    ////////////////////////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////////////////////////

    task automatic run_model();
        int         pc;
        word_t      w, a, b, imm_i, imm_s, sum;
        logic [5:0] op;
        reg_addr_t  rd;
        logic       taken;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        exp_q.delete();
        pc = 0;
        while (pc < prog_len - 1) begin
            w     = prog[pc];
            op    = w[31:26];
            rd    = w[25:20];
            a     = model_regs[w[19:14]];
            b     = model_regs[w[13:8]];
            imm_i = {{18{w[13]}}, w[13:0]};
            imm_s = {{24{w[7]}}, w[7:0]};
            pc    = pc + 1;
            case (op)
                OP_ADD:  model_regs[rd] = a + b;
                OP_SUB:  model_regs[rd] = a - b;
                OP_AND:  model_regs[rd] = a & b;
                OP_OR:   model_regs[rd] = a | b;
                OP_XOR:  model_regs[rd] = a ^ b;
                OP_SLT:  model_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: model_regs[rd] = a + imm_i;
                OP_LW: begin
                    sum            = a + imm_i;
                    model_regs[rd] = model_mem[sum[DW-1:0]];
                end
                OP_SW: begin
                    sum                    = a + imm_s;
                    model_mem[sum[DW-1:0]] = b;
                end
                OP_BEQ, OP_BNE: begin
                    taken = (op == OP_BEQ) ? (a == b) : (a != b);
                    if (taken) begin
                        pc = pc + int'($signed(w[7:0]));
                    end
                end
                OP_OUT:  exp_q.push_back(a[7:0]);
                // NOP and unknown opcodes
                default: begin
                end
            endcase
            model_regs[0] = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = IW'(i);
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
    endtask

    task automatic run_program();
        make_program();
        run_model();
        got_count = 0;
        load_program();
        rstn = 1'b0;
        repeat (10) next_cycle();
        rstn = 1'b1;
        next_cycle();
        hold = 1'b0;
        while (got_count < exp_q.size()) begin
            tx_full = ($urandom % 3 == 0);
            // short freezes while bytes may be pending
            hold    = ($urandom % 8 == 0);
            next_cycle();
        end
        hold = 1'b0;
        // core sits in the halt loop now
        repeat (50) begin
            tx_full = ($urandom % 3 == 0);
            next_cycle();
        end
        tx_full = 1'b0;
        hold    = 1'b1;
    endtask

    initial begin
        rstn      = 1'b0;
        hold      = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        tx_full   = 1'b0;
        void'($urandom(57));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) next_cycle();
        rstn = 1'b1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_num = p;
            run_program();
        end
        $display("summary: %0d programs, %0d bytes checked, %0d value errors, %0d protocol errors",
                 NUM_PROGS, bytes_checked, value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // output checker and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstn || hold) begin
            assert (tx_wr_en == 1'b0) else begin
                $display("tx_wr_en went high during reset or hold at %0t ns", $time);
                proto_errs++;
            end
        end
        assert (!(tx_wr_en && tx_full)) else begin
            $display("tx_wr_en high together with tx_full at %0t ns", $time);
            proto_errs++;
        end
        if (tx_wr_en) begin
            assert (got_count < exp_q.size()) else begin
                $display("extra output byte %02h in program %0d at %0t ns",
                         tx_data, prog_num, $time);
                proto_errs++;
            end
            if (got_count < exp_q.size()) begin
                assert (tx_data == exp_q[got_count]) else begin
                    $display("Fail at %0t ns: program %0d byte %0d expected %02h got %02h",
                             $time, prog_num, got_count, exp_q[got_count], tx_data);
                    value_errs++;
                end
                bytes_checked++;
            end
            got_count++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, program %0d got %0d of %0d bytes",
                     cycles, prog_num, got_count, exp_q.size());
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

/* vlog.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipeline_ctrl.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/exec_stage.sv
hw/mem_stage.sv
hw/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Finished with errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
